// File: tb.f
+incdir+.
ex_data_pkg.sv
ex_ctrl_pkg.sv
ex_stage_ifs.sv
alu.sv
npc_unit.sv
id_exe_reg.sv
exeu.sv
exe_mem_reg.sv
exe_slice_top.sv
tb_exe_slice.sv

// File: run.sh
#!/bin/sh
# compile and run the execute slice testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_exe_slice -f tb.f
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/Vtb_exe_slice)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi
echo "pass message not found"
exit 1

// File: tb_exe_slice.sv
// execute slice testbench
// reference model, handshake mirror and in-order scoreboard around exe_slice_top
`timescale 1ns/100ps
`include "ex_consts.svh"

module tb_exe_slice
	import ex_data_pkg::*, ex_ctrl_pkg::*;
();

	typedef struct packed {
		word_t     pc;
		word_t     imm;
		word_t     rs1;
		word_t     rs2;
		word_t     csr;
		alu_op_t   op;
		logic      src_a;
		logic      src_b;
		jump_t     jump;
		logic      we;
		gpr_addr_t waddr;
		wb_sel_t   wb;
		mem_acc_t  acc;
		logic      fence;
	} instr_t;

	typedef struct packed {
		word_t     pc;
		word_t     alu;
		word_t     rs2;
		word_t     wb;
		logic      we;
		gpr_addr_t waddr;
		mem_acc_t  acc;
	} res_t;

	// about 400 cycles of traffic over all tests
	localparam int STIM_CYCLES = 400;
	localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 200;

	logic clk;
	logic rst_n;
	logic dec_valid;
	logic dec_ready;
	logic icache_flush_done;
	word_t mtvec;
	word_t mepc;
	word_t npc;
	logic redirect_valid;
	logic fwd_is_load;
	word_t fwd_data;
	logic mem_valid;
	logic mem_ready;
	word_t mem_pc;
	word_t mem_alu_result;
	word_t mem_rs2_data;
	word_t mem_wb_data;
	logic mem_gpr_we;
	gpr_addr_t mem_gpr_waddr;
	mem_acc_t mem_acc_out;

	instr_t cur;
	res_t act_b;
	res_t prev_b;
	res_t exp_q[$];
	instr_t stage;
	logic stage_v;
	logic mem_v_m;
	logic hold_prev;
	logic bp_en;
	int errors;
	int checks;
	int cycles;
	string test_name;

	exe_slice_top i_dut (
		.clk (clk), .rst_n (rst_n), .dec_valid (dec_valid), .dec_ready (dec_ready),
		.pc (cur.pc), .imm (cur.imm), .rs1_data (cur.rs1), .rs2_data (cur.rs2),
		.csr_rdata (cur.csr), .alu_op (cur.op), .alu_src_a (cur.src_a),
		.alu_src_b (cur.src_b), .jump (cur.jump), .gpr_we (cur.we),
		.gpr_waddr (cur.waddr), .wb_sel (cur.wb), .mem_acc (cur.acc), .fence_i (cur.fence),
		.icache_flush_done (icache_flush_done), .mtvec (mtvec), .mepc (mepc),
		.npc (npc), .redirect_valid (redirect_valid), .fwd_is_load (fwd_is_load),
		.fwd_data (fwd_data), .mem_valid (mem_valid), .mem_ready (mem_ready),
		.mem_pc (mem_pc), .mem_alu_result (mem_alu_result), .mem_rs2_data (mem_rs2_data),
		.mem_wb_data (mem_wb_data), .mem_gpr_we (mem_gpr_we),
		.mem_gpr_waddr (mem_gpr_waddr), .mem_acc_out (mem_acc_out)
	);

	assign act_b = {mem_pc, mem_alu_result, mem_rs2_data, mem_wb_data,
		mem_gpr_we, mem_gpr_waddr, mem_acc_out};

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic word_t ref_alu(instr_t s);
		word_t a;
		word_t b;
		a = s.src_a ? s.pc : s.rs1;
		b = s.src_b ? s.imm : s.rs2;
		case (s.op)
			`EX_ALU_ADD:  return a + b;
			`EX_ALU_SUB:  return a - b;
			`EX_ALU_AND:  return a & b;
			`EX_ALU_OR:   return a | b;
			`EX_ALU_XOR:  return a ^ b;
			`EX_ALU_SLL:  return a << b[4:0];
			`EX_ALU_SRL:  return a >> b[4:0];
			`EX_ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
			`EX_ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			`EX_ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
			default:      return 32'd0;
		endcase
	endfunction

	// branch outcome taken straight from the compared operands
	function automatic word_t ref_npc(instr_t s);
		word_t a;
		word_t b;
		word_t seq_pc;
		word_t target;
		a = s.src_a ? s.pc : s.rs1;
		b = s.src_b ? s.imm : s.rs2;
		seq_pc = s.pc + 32'd4;
		target = s.pc + s.imm;
		case (s.jump)
			`EX_JMP_JAL:   return target;
			`EX_JMP_JALR:  return (s.rs1 + s.imm) & 32'hffff_fffe;
			`EX_JMP_BEQ:   return (a == b) ? target : seq_pc;
			`EX_JMP_BNE:   return (a != b) ? target : seq_pc;
			`EX_JMP_BLT:   return ($signed(a) < $signed(b)) ? target : seq_pc;
			`EX_JMP_BGE:   return ($signed(a) >= $signed(b)) ? target : seq_pc;
			`EX_JMP_BLTU:  return (a < b) ? target : seq_pc;
			`EX_JMP_BGEU:  return (a >= b) ? target : seq_pc;
			`EX_JMP_ECALL: return mtvec;
			`EX_JMP_MRET:  return mepc;
			default:       return seq_pc;
		endcase
	endfunction

	function automatic word_t ref_wb(instr_t s);
		case (s.wb)
			`EX_WB_IMM: return s.imm;
			`EX_WB_ALU: return ref_alu(s);
			`EX_WB_PC4: return s.pc + 32'd4;
			`EX_WB_CSR: return s.csr;
			default:    return 32'd0;
		endcase
	endfunction

	function automatic res_t ref_bundle(instr_t s);
		return {s.pc, ref_alu(s), s.rs2, ref_wb(s), s.we, s.waddr, s.acc};
	endfunction

	function automatic instr_t rand_instr();
		instr_t s;
		s.pc    = $urandom & 32'hffff_fffc;
		s.imm   = $urandom;
		s.rs1   = $urandom;
		s.rs2   = $urandom;
		s.csr   = $urandom;
		s.op    = alu_op_t'($urandom % 10);
		s.src_a = 1'($urandom % 2);
		s.src_b = 1'($urandom % 2);
		s.jump  = `EX_JMP_NONE;
		s.we    = 1'($urandom % 2);
		s.waddr = gpr_addr_t'($urandom % 16);
		s.wb    = `EX_WB_ALU;
		s.acc   = mem_acc_t'($urandom % 3);
		s.fence = 1'b0;
		return s;
	endfunction

	task automatic check_bit(input string what, input logic exp, input logic act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("FAILED %s %s: expected %0b actual %0b", test_name, what, exp, act);
		end
	endtask

	task automatic check_word(input string what, input word_t exp, input word_t act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	// called at edge+2, returns at edge+2 after the accepting edge
	task automatic send(input instr_t ins);
		cur = ins;
		dec_valid = 1'b1;
		@(negedge clk);
		while (!dec_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#2;
		dec_valid = 1'b0;
	endtask

	task automatic drain();
		do begin
			@(posedge clk);
		end while (exp_q.size() != 0);
		#2;
	endtask

	task automatic set_backpressure(input logic on);
		@(negedge clk);
		bp_en = on;
		@(posedge clk);
		#2;
	endtask

	always @(posedge clk) begin
		#2;
		mem_ready = bp_en ? 1'($urandom % 2) : 1'b1;
	end

	// all outputs are settled mid-cycle, so every check runs on the falling edge
	always @(negedge clk) begin : scoreboard
		logic  stall_m;
		logic  ex_ready_m;
		res_t  exp_b;
		word_t exp_npc;
		if (!rst_n) begin
			stage_v = 1'b0;
			mem_v_m = 1'b0;
			hold_prev = 1'b0;
		end else begin
			stall_m    = stage_v && stage.fence && !icache_flush_done;
			ex_ready_m = (!mem_v_m || mem_ready) && !stall_m;
			check_bit("dec_ready", !stage_v || ex_ready_m, dec_ready);
			check_bit("mem_valid", mem_v_m, mem_valid);
			if (stage_v) begin
				exp_npc = ref_npc(stage);
				check_word("npc", exp_npc, npc);
				check_bit("redirect_valid",
					(stage.jump != `EX_JMP_NONE) && (exp_npc != stage.pc + 32'd4), redirect_valid);
				check_bit("fwd_is_load", stage.acc == `EX_MEM_LOAD, fwd_is_load);
				check_word("fwd_data", ref_wb(stage), fwd_data);
			end else begin
				check_bit("redirect_valid idle", 1'b0, redirect_valid);
			end
			if (hold_prev) begin
				checks++;
				assert (act_b === prev_b) else begin
					errors++;
					$display("FAILED %s held bundle: expected %h actual %h", test_name, prev_b, act_b);
				end
			end
			if (mem_valid && mem_ready) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("%s: memory side took an item that was never issued", test_name);
				end else begin
					exp_b = exp_q.pop_front();
					checks++;
					assert (act_b === exp_b) else begin
						errors++;
						$display("FAILED %s mem bundle: expected %h actual %h", test_name, exp_b, act_b);
					end
				end
			end
			if (dec_valid && dec_ready) begin
				exp_q.push_back(ref_bundle(cur));
			end
			// mirror state after the coming rising edge
			hold_prev = mem_valid && !mem_ready;
			prev_b = act_b;
			if (stage_v && ex_ready_m) begin
				mem_v_m = 1'b1;
			end else if (mem_ready) begin
				mem_v_m = 1'b0;
			end
			if (dec_valid && dec_ready) begin
				stage = cur;
				stage_v = 1'b1;
			end else if (ex_ready_m) begin
				stage_v = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	initial begin : stimulus
		instr_t ins;
		void'($urandom(32'h2366_e727));
		rst_n = 1'b0;
		dec_valid = 1'b0;
		cur = '0;
		icache_flush_done = 1'b1;
		mem_ready = 1'b1;
		bp_en = 1'b0;
		mtvec = $urandom & 32'hffff_fffc;
		mepc = $urandom & 32'hffff_fffc;
		test_name = "reset";
		repeat (8) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		check_bit("mem_valid after reset", 1'b0, mem_valid);
		check_bit("redirect_valid after reset", 1'b0, redirect_valid);
		check_bit("dec_ready after reset", 1'b1, dec_ready);
		@(posedge clk);
		#2;

		test_name = "alu";
		for (int op = 0; op < 10; op++) begin
			for (int sel = 0; sel < 4; sel++) begin
				for (int k = 0; k < 3; k++) begin
					ins = rand_instr();
					ins.op = alu_op_t'(op);
					ins.src_a = sel[1];
					ins.src_b = sel[0];
					send(ins);
				end
			end
		end

		// branches compare rs1 against rs2, equal in half the cases, rs2 one above in a quarter
		test_name = "control";
		for (int j = 1; j <= 10; j++) begin
			for (int k = 0; k < 8; k++) begin
				ins = rand_instr();
				ins.jump = jump_t'(j);
				ins.src_a = 1'b0;
				ins.src_b = 1'b0;
				ins.wb = `EX_WB_PC4;
				if (k % 2 == 0) begin
					ins.rs2 = ins.rs1;
				end else if (k % 4 == 1) begin
					ins.rs2 = ins.rs1 + 32'd1;
				end
				case (ins.jump)
					`EX_JMP_BEQ, `EX_JMP_BNE:   ins.op = `EX_ALU_SUB;
					`EX_JMP_BLT, `EX_JMP_BGE:   ins.op = `EX_ALU_SLT;
					`EX_JMP_BLTU, `EX_JMP_BGEU: ins.op = `EX_ALU_SLTU;
					default:                    ins.op = `EX_ALU_ADD;
				endcase
				send(ins);
			end
		end
		drain();

		test_name = "backpressure";
		set_backpressure(1'b1);
		repeat (60) begin
			ins = rand_instr();
			ins.wb = wb_sel_t'($urandom % 8);
			send(ins);
		end
		drain();
		set_backpressure(1'b0);

		test_name = "fence_i";
		icache_flush_done = 1'b0;
		ins = rand_instr();
		ins.fence = 1'b1;
		send(ins);
		cur = rand_instr();
		dec_valid = 1'b1;
		repeat (12) begin
			@(negedge clk);
			check_bit("stalled dec_ready", 1'b0, dec_ready);
			check_bit("stalled mem_valid", 1'b0, mem_valid);
		end
		@(posedge clk);
		#2;
		icache_flush_done = 1'b1;
		send(cur);
		drain();

		test_name = "forward";
		for (int w = 0; w < 8; w++) begin
			for (int m = 0; m < 3; m++) begin
				ins = rand_instr();
				ins.wb = wb_sel_t'(w);
				ins.acc = mem_acc_t'(m);
				send(ins);
			end
		end
		drain();

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: exe_slice_top.sv
// execute slice top level
// decode/execute register, execute stage and execute/memory register
`timescale 1ns/100ps

module exe_slice_top
	import ex_data_pkg::*, ex_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      dec_valid,
	output logic      dec_ready,
	input  word_t     pc,
	input  word_t     imm,
	input  word_t     rs1_data,
	input  word_t     rs2_data,
	input  word_t     csr_rdata,
	input  alu_op_t   alu_op,
	input  logic      alu_src_a,
	input  logic      alu_src_b,
	input  jump_t     jump,
	input  logic      gpr_we,
	input  gpr_addr_t gpr_waddr,
	input  wb_sel_t   wb_sel,
	input  mem_acc_t  mem_acc,
	input  logic      fence_i,
	input  logic      icache_flush_done,
	input  word_t     mtvec,
	input  word_t     mepc,
	output word_t     npc,
	output logic      redirect_valid,
	output logic      fwd_is_load,
	output word_t     fwd_data,
	output logic      mem_valid,
	input  logic      mem_ready,
	output word_t     mem_pc,
	output word_t     mem_alu_result,
	output word_t     mem_rs2_data,
	output word_t     mem_wb_data,
	output logic      mem_gpr_we,
	output gpr_addr_t mem_gpr_waddr,
	output mem_acc_t  mem_acc_out
);

	ex_issue_if  issue_bus ();
	ex_result_if result_bus ();

	id_exe_reg u_id_exe (
		.clk, .rst_n, .dec_valid, .dec_ready,
		.pc, .imm, .rs1_data, .rs2_data, .csr_rdata,
		.alu_op, .alu_src_a, .alu_src_b, .jump,
		.gpr_we, .gpr_waddr, .wb_sel, .mem_acc, .fence_i,
		.issue (issue_bus.source)
	);

	exeu u_exeu (
		.issue  (issue_bus.sink),
		.icache_flush_done, .mtvec, .mepc,
		.result (result_bus.source),
		.npc, .redirect_valid, .fwd_is_load, .fwd_data
	);

	exe_mem_reg u_exe_mem (
		.clk, .rst_n,
		.result (result_bus.sink),
		.mem_valid, .mem_ready, .mem_pc, .mem_alu_result, .mem_rs2_data,
		.mem_wb_data, .mem_gpr_we, .mem_gpr_waddr, .mem_acc_out
	);

endmodule

// File: exe_mem_reg.sv
// execute/memory pipeline register
// one entry with valid/ready, drained by the memory stage
`timescale 1ns/100ps

module exe_mem_reg
	import ex_data_pkg::*, ex_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	ex_result_if.sink  result,
	output logic       mem_valid,
	input  logic       mem_ready,
	output word_t      mem_pc,
	output word_t      mem_alu_result,
	output word_t      mem_rs2_data,
	output word_t      mem_wb_data,
	output logic       mem_gpr_we,
	output gpr_addr_t  mem_gpr_waddr,
	output mem_acc_t   mem_acc_out
);

	logic load;

	assign result.ready = !mem_valid || mem_ready;
	assign load         = result.valid && result.ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_valid <= 1'b0;
		end else if (load) begin
			mem_valid <= 1'b1;
		end else if (mem_ready) begin
			mem_valid <= 1'b0;
		end
	end

	// payload held while the memory stage stalls
	always_ff @(posedge clk) begin
		if (load) begin
			mem_pc         <= result.pc;
			mem_alu_result <= result.alu_result;
			mem_rs2_data   <= result.rs2_data;
			mem_wb_data    <= result.wb_data;
			mem_gpr_we     <= result.gpr_we;
			mem_gpr_waddr  <= result.gpr_waddr;
			mem_acc_out    <= result.mem_acc;
		end
	end

endmodule

// File: exeu.sv
// execute stage
// operand select, alu, next pc and redirect, fence.i stall and forwarding
`timescale 1ns/100ps
`include "ex_consts.svh"

module exeu
	import ex_data_pkg::*, ex_ctrl_pkg::*;
(
	ex_issue_if.sink     issue,
	input  logic         icache_flush_done,
	input  word_t        mtvec,
	input  word_t        mepc,
	ex_result_if.source  result,
	output word_t        npc,
	output logic         redirect_valid,
	output logic         fwd_is_load,
	output word_t        fwd_data
);

	logic  stall;
	word_t op_a;
	word_t op_b;
	word_t alu_res;
	logic  alu_zero;
	word_t pc_plus4;
	word_t wb_data;

	// hold the fence.i here until the icache flush completes
	assign stall        = issue.fence_i && !icache_flush_done;
	assign result.valid = issue.valid && !stall;
	assign issue.ready  = result.ready && !stall;

	assign op_a = issue.alu_src_a ? issue.pc : issue.rs1_data;
	assign op_b = issue.alu_src_b ? issue.imm : issue.rs2_data;

	alu u_alu (
		.a      (op_a),
		.b      (op_b),
		.op     (issue.alu_op),
		.result (alu_res),
		.zero   (alu_zero)
	);

	// branch compares come from the alu (sub for eq/ne, slt/sltu for the rest)
	npc_unit u_npc (
		.pc       (issue.pc),
		.imm      (issue.imm),
		.rs1_data (issue.rs1_data),
		.mtvec    (mtvec),
		.mepc     (mepc),
		.jump     (issue.jump),
		.cmp_bit  (alu_res[0]),
		.zero     (alu_zero),
		.npc      (npc)
	);

	assign pc_plus4 = issue.pc + 32'd4;

	// only redirect when the target really leaves the sequential path
	assign redirect_valid = issue.valid && (issue.jump != `EX_JMP_NONE) && (npc != pc_plus4);

	always_comb begin
		case (issue.wb_sel)
			`EX_WB_IMM: wb_data = issue.imm;
			`EX_WB_ALU: wb_data = alu_res;
			`EX_WB_PC4: wb_data = pc_plus4;
			`EX_WB_CSR: wb_data = issue.csr_rdata;
			default:    wb_data = '0;
		endcase
	end

	assign result.pc         = issue.pc;
	assign result.alu_result = alu_res;
	assign result.rs2_data   = issue.rs2_data;
	assign result.wb_data    = wb_data;
	assign result.gpr_we     = issue.gpr_we;
	assign result.gpr_waddr  = issue.gpr_waddr;
	assign result.mem_acc    = issue.mem_acc;

	// forwarding taps, load data is not ready yet in this stage
	assign fwd_is_load = (issue.mem_acc == `EX_MEM_LOAD);
	assign fwd_data    = wb_data;

endmodule

// File: id_exe_reg.sv
// decode/execute pipeline register
// one entry with valid/ready on both sides
`timescale 1ns/100ps

module id_exe_reg
	import ex_data_pkg::*, ex_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      dec_valid,
	output logic      dec_ready,
	input  word_t     pc,
	input  word_t     imm,
	input  word_t     rs1_data,
	input  word_t     rs2_data,
	input  word_t     csr_rdata,
	input  alu_op_t   alu_op,
	input  logic      alu_src_a,
	input  logic      alu_src_b,
	input  jump_t     jump,
	input  logic      gpr_we,
	input  gpr_addr_t gpr_waddr,
	input  wb_sel_t   wb_sel,
	input  mem_acc_t  mem_acc,
	input  logic      fence_i,
	ex_issue_if.source issue
);

	logic load;

	// accept when empty or when the current entry leaves this cycle
	assign dec_ready = !issue.valid || issue.ready;
	assign load      = dec_valid && dec_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issue.valid <= 1'b0;
		end else if (load) begin
			issue.valid <= 1'b1;
		end else if (issue.ready) begin
			issue.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			issue.pc        <= pc;
			issue.imm       <= imm;
			issue.rs1_data  <= rs1_data;
			issue.rs2_data  <= rs2_data;
			issue.csr_rdata <= csr_rdata;
			issue.alu_op    <= alu_op;
			issue.alu_src_a <= alu_src_a;
			issue.alu_src_b <= alu_src_b;
			issue.jump      <= jump;
			issue.gpr_we    <= gpr_we;
			issue.gpr_waddr <= gpr_waddr;
			issue.wb_sel    <= wb_sel;
			issue.mem_acc   <= mem_acc;
			issue.fence_i   <= fence_i;
		end
	end

endmodule

// File: npc_unit.sv
// next pc unit
// targets for jumps, branches, trap entry and mret
`timescale 1ns/100ps
`include "ex_consts.svh"

module npc_unit
	import ex_data_pkg::*, ex_ctrl_pkg::*;
(
	input  word_t pc,
	input  word_t imm,
	input  word_t rs1_data,
	input  word_t mtvec,
	input  word_t mepc,
	input  jump_t jump,
	input  logic  cmp_bit,
	input  logic  zero,
	output word_t npc
);

	word_t pc_plus4;
	word_t pc_target;
	word_t jalr_sum;
	logic  taken;

	assign pc_plus4  = pc + 32'd4;
	assign pc_target = pc + imm;
	assign jalr_sum  = rs1_data + imm;

	// zero from sub for eq/ne, cmp_bit from slt/sltu otherwise
	always_comb begin
		case (jump)
			`EX_JMP_BEQ:  taken = zero;
			`EX_JMP_BNE:  taken = !zero;
			`EX_JMP_BLT,
			`EX_JMP_BLTU: taken = cmp_bit;
			`EX_JMP_BGE,
			`EX_JMP_BGEU: taken = !cmp_bit;
			default:      taken = 1'b0;
		endcase
	end

	always_comb begin
		case (jump)
			`EX_JMP_JAL:   npc = pc_target;
			`EX_JMP_JALR:  npc = {jalr_sum[`EX_XLEN-1:1], 1'b0};
			`EX_JMP_ECALL: npc = mtvec;
			`EX_JMP_MRET:  npc = mepc;
			default:       npc = taken ? pc_target : pc_plus4;
		endcase
	end

endmodule

// File: alu.sv
// 32-bit alu
// add/sub, logic, shifts and set-less-than with a zero flag
`timescale 1ns/100ps
`include "ex_consts.svh"

module alu
	import ex_data_pkg::*, ex_ctrl_pkg::*;
(
	input  word_t   a,
	input  word_t   b,
	input  alu_op_t op,
	output word_t   result,
	output logic    zero
);

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	// only the low five bits count for shifts
	assign shamt = b[4:0];
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;

	always_comb begin
		case (op)
			`EX_ALU_ADD:  result = a + b;
			`EX_ALU_SUB:  result = a - b;
			`EX_ALU_AND:  result = a & b;
			`EX_ALU_OR:   result = a | b;
			`EX_ALU_XOR:  result = a ^ b;
			`EX_ALU_SLL:  result = a << shamt;
			`EX_ALU_SRL:  result = a >> shamt;
			`EX_ALU_SRA:  result = word_t'($signed(a) >>> shamt);
			`EX_ALU_SLT:  result = {{(`EX_XLEN-1){1'b0}}, lt_s};
			`EX_ALU_SLTU: result = {{(`EX_XLEN-1){1'b0}}, lt_u};
			default:      result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

// File: ex_stage_ifs.sv
// execute stage bundles
// issue bundle from the decode/execute register, result bundle to exe/mem register
`timescale 1ns/100ps

interface ex_issue_if
	import ex_data_pkg::*, ex_ctrl_pkg::*;
;
	logic     valid;
	logic     ready;
	word_t    pc;
	word_t    imm;
	word_t    rs1_data;
	word_t    rs2_data;
	word_t    csr_rdata;
	alu_op_t  alu_op;
	logic     alu_src_a;
	logic     alu_src_b;
	jump_t    jump;
	logic     gpr_we;
	gpr_addr_t gpr_waddr;
	wb_sel_t  wb_sel;
	mem_acc_t mem_acc;
	logic     fence_i;

	modport source (
		output valid, pc, imm, rs1_data, rs2_data, csr_rdata, alu_op, alu_src_a,
			alu_src_b, jump, gpr_we, gpr_waddr, wb_sel, mem_acc, fence_i,
		input ready
	);
	modport sink (
		input valid, pc, imm, rs1_data, rs2_data, csr_rdata, alu_op, alu_src_a,
			alu_src_b, jump, gpr_we, gpr_waddr, wb_sel, mem_acc, fence_i,
		output ready
	);
endinterface

interface ex_result_if
	import ex_data_pkg::*, ex_ctrl_pkg::*;
;
	logic      valid;
	logic      ready;
	word_t     pc;
	word_t     alu_result;
	word_t     rs2_data;
	word_t     wb_data;
	logic      gpr_we;
	gpr_addr_t gpr_waddr;
	mem_acc_t  mem_acc;

	modport source (
		output valid, pc, alu_result, rs2_data, wb_data, gpr_we, gpr_waddr, mem_acc,
		input ready
	);
	modport sink (
		input valid, pc, alu_result, rs2_data, wb_data, gpr_we, gpr_waddr, mem_acc,
		output ready
	);
endinterface

// File: ex_ctrl_pkg.sv
// execute slice control field types
// decoded control fields carried along with each instruction
`include "ex_consts.svh"

package ex_ctrl_pkg;

	// alu operation select
	typedef logic [`EX_ALU_OP_W-1:0] alu_op_t;

	// jump, branch or trap kind
	typedef logic [`EX_JMP_W-1:0] jump_t;

	// which value goes back to the register file
	typedef logic [`EX_WB_W-1:0] wb_sel_t;

	// load, store or none
	typedef logic [`EX_MEM_W-1:0] mem_acc_t;

endpackage

// File: ex_data_pkg.sv
// execute slice datapath types
// data words and register file / csr addresses
`include "ex_consts.svh"

package ex_data_pkg;

	// one architectural data word
	typedef logic [`EX_XLEN-1:0] word_t;

	// rv32e has 16 integer registers
	typedef logic [`EX_GPR_AW-1:0] gpr_addr_t;

	typedef logic [`EX_CSR_AW-1:0] csr_addr_t;

endpackage

// File: ex_consts.svh
// execute slice constants
// widths and the control field encodings shared by the execute datapath
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

`define EX_XLEN       32
`define EX_GPR_AW     4
`define EX_CSR_AW     12
`define EX_ALU_OP_W   4
`define EX_JMP_W      4
`define EX_WB_W       3
`define EX_MEM_W      2

// alu operations
`define EX_ALU_ADD    4'd0
`define EX_ALU_SUB    4'd1
`define EX_ALU_AND    4'd2
`define EX_ALU_OR     4'd3
`define EX_ALU_XOR    4'd4
`define EX_ALU_SLL    4'd5
`define EX_ALU_SRL    4'd6
`define EX_ALU_SRA    4'd7
`define EX_ALU_SLT    4'd8
`define EX_ALU_SLTU   4'd9

// control transfer kinds
`define EX_JMP_NONE   4'd0
`define EX_JMP_JAL    4'd1
`define EX_JMP_JALR   4'd2
`define EX_JMP_BEQ    4'd3
`define EX_JMP_BNE    4'd4
`define EX_JMP_BLT    4'd5
`define EX_JMP_BGE    4'd6
`define EX_JMP_BLTU   4'd7
`define EX_JMP_BGEU   4'd8
`define EX_JMP_ECALL  4'd9
`define EX_JMP_MRET   4'd10

// writeback source
`define EX_WB_IMM     3'd0
`define EX_WB_ALU     3'd1
`define EX_WB_PC4     3'd2
`define EX_WB_CSR     3'd4

// memory access kind
`define EX_MEM_NONE   2'd0
`define EX_MEM_LOAD   2'd1
`define EX_MEM_STORE  2'd2

`endif
